// File: rtl/issue_lane.sv
`include "issue_macros.svh"

module issue_lane import issue_pkg::*; (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_stall_dcache,
    input  logic                      i_stall_ex,
    input  logic                      i_flush_br,
    input  logic                      i_valid,
    input  logic [`ISSUE_XLEN-1:0]    i_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_pc_pre,
    input  logic [`ISSUE_XLEN-1:0]    i_imm,
    input  logic [`ISSUE_XLEN-1:0]    i_rdata1,
    input  logic [`ISSUE_XLEN-1:0]    i_rdata2,
    input  logic [`ISSUE_XLEN-1:0]    i_csr_rdata,
    input  inst_class_e               i_class,
    input  alu_op_e                   i_alu_op,
    input  logic                      i_rf_we,
    input  logic [`ISSUE_REG_AW-1:0]  i_rf_waddr,
    input  logic                      i_mem_we,
    output logic                      o_valid,
    output logic [`ISSUE_XLEN-1:0]    o_pc,
    output logic [`ISSUE_XLEN-1:0]    o_next_pc,
    output logic [`ISSUE_XLEN-1:0]    o_imm,
    output logic [`ISSUE_XLEN-1:0]    o_rdata1,
    output logic [`ISSUE_XLEN-1:0]    o_rdata2,
    output logic [`ISSUE_XLEN-1:0]    o_csr_rdata,
    output logic                      o_br_pd,
    output inst_class_e               o_class,
    output alu_op_e                   o_alu_op,
    output logic                      o_rf_we,
    output logic [`ISSUE_REG_AW-1:0]  o_rf_waddr,
    output logic                      o_mem_we
);

    logic                   stall;
    logic [`ISSUE_XLEN-1:0] pc_pre_q;
    logic [`ISSUE_XLEN-1:0] seq_pc;

    assign stall = i_stall_dcache | i_stall_ex;

    ////////////////////////////////////////
    // Slot register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || i_flush_br) begin  // Flush wins over stall
            o_valid     <= 1'b0;
            o_pc        <= '0;
            pc_pre_q    <= `ISSUE_XLEN'(`ISSUE_INST_BYTES);  // Reads as not taken
            o_imm       <= '0;
            o_rdata1    <= '0;
            o_rdata2    <= '0;
            o_csr_rdata <= '0;
            o_class     <= CLS_ALU;
            o_alu_op    <= OP_ADD;
            o_rf_we     <= 1'b0;
            o_rf_waddr  <= '0;
            o_mem_we    <= 1'b0;
        end else if (!stall) begin
            o_valid     <= i_valid;
            o_pc        <= i_pc;
            pc_pre_q    <= i_pc_pre;
            o_imm       <= i_imm;
            o_rdata1    <= i_rdata1;
            o_rdata2    <= i_rdata2;
            o_csr_rdata <= i_csr_rdata;
            o_class     <= i_class;
            o_alu_op    <= i_alu_op;
            o_rf_we     <= i_rf_we & i_valid;   // No writes from a bubble
            o_rf_waddr  <= i_rf_waddr;
            o_mem_we    <= i_mem_we & i_valid;
        end
    end

    ////////////////////////////////////////
    // Prediction and next PC
    ////////////////////////////////////////

    assign seq_pc    = o_pc + `ISSUE_XLEN'(`ISSUE_INST_BYTES);
    assign o_br_pd   = (pc_pre_q != seq_pc);          // Predicted away from fall-through
    assign o_next_pc = o_valid ? pc_pre_q : seq_pc;

endmodule

// File: rtl/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// PC and data width
`define ISSUE_XLEN 32
// GPR index width
`define ISSUE_REG_AW 5
// Step of the sequential PC
`define ISSUE_INST_BYTES 4

////////////////////////////////////////
// Enum encoding widths
////////////////////////////////////////

`define ISSUE_CLS_W 3
`define ISSUE_OP_W 4

`endif

// File: rtl/issue_pkg.sv
`include "issue_macros.svh"

package issue_pkg;

    // Execute unit an instruction needs
    typedef enum logic [`ISSUE_CLS_W-1:0] {
        CLS_ALU   = 3'd0,  // Either lane
        CLS_MUL   = 3'd1,  // Lane B only
        CLS_DIV   = 3'd2,
        CLS_ERTN  = 3'd3,
        CLS_CACOP = 3'd4
    } inst_class_e;

    typedef enum logic [`ISSUE_OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9   // Unsigned compare
    } alu_op_e;

endpackage

// File: rtl/issue_route.sv
`include "issue_macros.svh"

module issue_route import issue_pkg::*; (
    input  logic                      i_s0_valid,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_next_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_imm,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_rdata1,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_rdata2,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_csr_rdata,
    input  logic                      i_s0_br_pd,
    input  inst_class_e               i_s0_class,
    input  alu_op_e                   i_s0_alu_op,
    input  logic                      i_s0_rf_we,
    input  logic [`ISSUE_REG_AW-1:0]  i_s0_rf_waddr,
    input  logic                      i_s0_mem_we,
    input  logic                      i_s1_valid,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_next_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_imm,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_rdata1,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_rdata2,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_csr_rdata,
    input  logic                      i_s1_br_pd,
    input  inst_class_e               i_s1_class,
    input  alu_op_e                   i_s1_alu_op,
    input  logic                      i_s1_rf_we,
    input  logic [`ISSUE_REG_AW-1:0]  i_s1_rf_waddr,
    input  logic                      i_s1_mem_we,
    output logic                      o_ex_a_valid,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_pc,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_next_pc,
    output logic                      o_ex_a_br_pd,
    output alu_op_e                   o_ex_a_alu_op,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_imm,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_rdata1,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_rdata2,
    output logic                      o_ex_a_rf_we,
    output logic [`ISSUE_REG_AW-1:0]  o_ex_a_rf_waddr,
    output logic                      o_ex_a_mem_we,
    output logic                      o_ex_b_valid,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_pc,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_next_pc,
    output logic                      o_ex_b_br_pd,
    output alu_op_e                   o_ex_b_alu_op,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_imm,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_rdata1,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_rdata2,
    output logic                      o_ex_b_rf_we,
    output logic [`ISSUE_REG_AW-1:0]  o_ex_b_rf_waddr,
    output logic                      o_ex_b_mem_we,
    output logic                      o_div_en,
    output logic                      o_mul_en,
    output logic                      o_ertn_check,
    output logic                      o_cacop_en,
    output logic [`ISSUE_XLEN-1:0]    o_csr_rdata
);

    logic        swap;
    logic        b_valid;
    inst_class_e b_class;

    // Special units hang off lane B only
    assign swap = (i_s0_class != CLS_ALU);

    ////////////////////////////////////////
    // Lane A
    ////////////////////////////////////////

    assign o_ex_a_valid    = swap ? i_s1_valid    : i_s0_valid;
    assign o_ex_a_pc       = swap ? i_s1_pc       : i_s0_pc;
    assign o_ex_a_next_pc  = swap ? i_s1_next_pc  : i_s0_next_pc;
    assign o_ex_a_br_pd    = swap ? i_s1_br_pd    : i_s0_br_pd;
    assign o_ex_a_alu_op   = swap ? i_s1_alu_op   : i_s0_alu_op;
    assign o_ex_a_imm      = swap ? i_s1_imm      : i_s0_imm;
    assign o_ex_a_rdata1   = swap ? i_s1_rdata1   : i_s0_rdata1;
    assign o_ex_a_rdata2   = swap ? i_s1_rdata2   : i_s0_rdata2;
    assign o_ex_a_rf_we    = swap ? i_s1_rf_we    : i_s0_rf_we;
    assign o_ex_a_rf_waddr = swap ? i_s1_rf_waddr : i_s0_rf_waddr;
    assign o_ex_a_mem_we   = swap ? i_s1_mem_we   : i_s0_mem_we;

    ////////////////////////////////////////
    // Lane B and special units
    ////////////////////////////////////////

    assign b_valid         = swap ? i_s0_valid    : i_s1_valid;
    assign b_class         = swap ? i_s0_class    : i_s1_class;
    assign o_ex_b_valid    = b_valid;
    assign o_ex_b_pc       = swap ? i_s0_pc       : i_s1_pc;
    assign o_ex_b_next_pc  = swap ? i_s0_next_pc  : i_s1_next_pc;
    assign o_ex_b_br_pd    = swap ? i_s0_br_pd    : i_s1_br_pd;
    assign o_ex_b_alu_op   = swap ? i_s0_alu_op   : i_s1_alu_op;
    assign o_ex_b_imm      = swap ? i_s0_imm      : i_s1_imm;
    assign o_ex_b_rdata1   = swap ? i_s0_rdata1   : i_s1_rdata1;
    assign o_ex_b_rdata2   = swap ? i_s0_rdata2   : i_s1_rdata2;
    assign o_ex_b_rf_we    = swap ? i_s0_rf_we    : i_s1_rf_we;
    assign o_ex_b_rf_waddr = swap ? i_s0_rf_waddr : i_s1_rf_waddr;
    assign o_ex_b_mem_we   = swap ? i_s0_mem_we   : i_s1_mem_we;

    assign o_div_en     = b_valid && (b_class == CLS_DIV);
    assign o_mul_en     = b_valid && (b_class == CLS_MUL);
    assign o_ertn_check = b_valid && (b_class == CLS_ERTN);
    assign o_cacop_en   = b_valid && (b_class == CLS_CACOP);
    assign o_csr_rdata  = swap ? i_s0_csr_rdata : i_s1_csr_rdata;  // From the lane-B slot

endmodule

// File: rtl/issue_top.sv
`include "issue_macros.svh"

module issue_top import issue_pkg::*; (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_stall_dcache,
    input  logic                      i_stall_ex,
    input  logic                      i_flush_br,
    input  logic                      i_s0_valid,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_pc_pre,
    input  inst_class_e               i_s0_class,
    input  alu_op_e                   i_s0_alu_op,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_imm,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_rdata1,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_rdata2,
    input  logic [`ISSUE_XLEN-1:0]    i_s0_csr_rdata,
    input  logic                      i_s0_rf_we,
    input  logic [`ISSUE_REG_AW-1:0]  i_s0_rf_waddr,
    input  logic                      i_s0_mem_we,
    input  logic                      i_s1_valid,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_pc,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_pc_pre,
    input  inst_class_e               i_s1_class,
    input  alu_op_e                   i_s1_alu_op,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_imm,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_rdata1,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_rdata2,
    input  logic [`ISSUE_XLEN-1:0]    i_s1_csr_rdata,
    input  logic                      i_s1_rf_we,
    input  logic [`ISSUE_REG_AW-1:0]  i_s1_rf_waddr,
    input  logic                      i_s1_mem_we,
    output logic                      o_ex_a_valid,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_pc,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_next_pc,
    output logic                      o_ex_a_br_pd,
    output alu_op_e                   o_ex_a_alu_op,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_imm,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_rdata1,
    output logic [`ISSUE_XLEN-1:0]    o_ex_a_rdata2,
    output logic                      o_ex_a_rf_we,
    output logic [`ISSUE_REG_AW-1:0]  o_ex_a_rf_waddr,
    output logic                      o_ex_a_mem_we,
    output logic                      o_ex_b_valid,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_pc,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_next_pc,
    output logic                      o_ex_b_br_pd,
    output alu_op_e                   o_ex_b_alu_op,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_imm,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_rdata1,
    output logic [`ISSUE_XLEN-1:0]    o_ex_b_rdata2,
    output logic                      o_ex_b_rf_we,
    output logic [`ISSUE_REG_AW-1:0]  o_ex_b_rf_waddr,
    output logic                      o_ex_b_mem_we,
    output logic                      o_div_en,
    output logic                      o_mul_en,
    output logic                      o_ertn_check,
    output logic                      o_cacop_en,
    output logic [`ISSUE_XLEN-1:0]    o_csr_rdata
);

    ////////////////////////////////////////
    // Registered slots
    ////////////////////////////////////////

    logic                     s0_valid,     s1_valid;
    logic [`ISSUE_XLEN-1:0]   s0_pc,        s1_pc;
    logic [`ISSUE_XLEN-1:0]   s0_next_pc,   s1_next_pc;
    logic [`ISSUE_XLEN-1:0]   s0_imm,       s1_imm;
    logic [`ISSUE_XLEN-1:0]   s0_rdata1,    s1_rdata1;
    logic [`ISSUE_XLEN-1:0]   s0_rdata2,    s1_rdata2;
    logic [`ISSUE_XLEN-1:0]   s0_csr_rdata, s1_csr_rdata;
    logic                     s0_br_pd,     s1_br_pd;
    inst_class_e              s0_class,     s1_class;
    alu_op_e                  s0_alu_op,    s1_alu_op;
    logic                     s0_rf_we,     s1_rf_we;
    logic [`ISSUE_REG_AW-1:0] s0_rf_waddr,  s1_rf_waddr;
    logic                     s0_mem_we,    s1_mem_we;

    issue_lane lane0 (
        .clk(clk), .rstn(rstn),
        .i_stall_dcache(i_stall_dcache), .i_stall_ex(i_stall_ex), .i_flush_br(i_flush_br),
        .i_valid(i_s0_valid), .i_pc(i_s0_pc), .i_pc_pre(i_s0_pc_pre),
        .i_imm(i_s0_imm), .i_rdata1(i_s0_rdata1), .i_rdata2(i_s0_rdata2),
        .i_csr_rdata(i_s0_csr_rdata), .i_class(i_s0_class), .i_alu_op(i_s0_alu_op),
        .i_rf_we(i_s0_rf_we), .i_rf_waddr(i_s0_rf_waddr), .i_mem_we(i_s0_mem_we),
        .o_valid(s0_valid), .o_pc(s0_pc), .o_next_pc(s0_next_pc),
        .o_imm(s0_imm), .o_rdata1(s0_rdata1), .o_rdata2(s0_rdata2),
        .o_csr_rdata(s0_csr_rdata), .o_br_pd(s0_br_pd), .o_class(s0_class),
        .o_alu_op(s0_alu_op), .o_rf_we(s0_rf_we), .o_rf_waddr(s0_rf_waddr),
        .o_mem_we(s0_mem_we)
    );

    issue_lane lane1 (
        .clk(clk), .rstn(rstn),
        .i_stall_dcache(i_stall_dcache), .i_stall_ex(i_stall_ex), .i_flush_br(i_flush_br),
        .i_valid(i_s1_valid), .i_pc(i_s1_pc), .i_pc_pre(i_s1_pc_pre),
        .i_imm(i_s1_imm), .i_rdata1(i_s1_rdata1), .i_rdata2(i_s1_rdata2),
        .i_csr_rdata(i_s1_csr_rdata), .i_class(i_s1_class), .i_alu_op(i_s1_alu_op),
        .i_rf_we(i_s1_rf_we), .i_rf_waddr(i_s1_rf_waddr), .i_mem_we(i_s1_mem_we),
        .o_valid(s1_valid), .o_pc(s1_pc), .o_next_pc(s1_next_pc),
        .o_imm(s1_imm), .o_rdata1(s1_rdata1), .o_rdata2(s1_rdata2),
        .o_csr_rdata(s1_csr_rdata), .o_br_pd(s1_br_pd), .o_class(s1_class),
        .o_alu_op(s1_alu_op), .o_rf_we(s1_rf_we), .o_rf_waddr(s1_rf_waddr),
        .o_mem_we(s1_mem_we)
    );

    ////////////////////////////////////////
    // Lane steering
    ////////////////////////////////////////

    issue_route route0 (
        .i_s0_valid(s0_valid), .i_s0_pc(s0_pc), .i_s0_next_pc(s0_next_pc),
        .i_s0_imm(s0_imm), .i_s0_rdata1(s0_rdata1), .i_s0_rdata2(s0_rdata2),
        .i_s0_csr_rdata(s0_csr_rdata), .i_s0_br_pd(s0_br_pd), .i_s0_class(s0_class),
        .i_s0_alu_op(s0_alu_op), .i_s0_rf_we(s0_rf_we), .i_s0_rf_waddr(s0_rf_waddr),
        .i_s0_mem_we(s0_mem_we),
        .i_s1_valid(s1_valid), .i_s1_pc(s1_pc), .i_s1_next_pc(s1_next_pc),
        .i_s1_imm(s1_imm), .i_s1_rdata1(s1_rdata1), .i_s1_rdata2(s1_rdata2),
        .i_s1_csr_rdata(s1_csr_rdata), .i_s1_br_pd(s1_br_pd), .i_s1_class(s1_class),
        .i_s1_alu_op(s1_alu_op), .i_s1_rf_we(s1_rf_we), .i_s1_rf_waddr(s1_rf_waddr),
        .i_s1_mem_we(s1_mem_we),
        .o_ex_a_valid(o_ex_a_valid), .o_ex_a_pc(o_ex_a_pc), .o_ex_a_next_pc(o_ex_a_next_pc),
        .o_ex_a_br_pd(o_ex_a_br_pd), .o_ex_a_alu_op(o_ex_a_alu_op), .o_ex_a_imm(o_ex_a_imm),
        .o_ex_a_rdata1(o_ex_a_rdata1), .o_ex_a_rdata2(o_ex_a_rdata2),
        .o_ex_a_rf_we(o_ex_a_rf_we), .o_ex_a_rf_waddr(o_ex_a_rf_waddr),
        .o_ex_a_mem_we(o_ex_a_mem_we),
        .o_ex_b_valid(o_ex_b_valid), .o_ex_b_pc(o_ex_b_pc), .o_ex_b_next_pc(o_ex_b_next_pc),
        .o_ex_b_br_pd(o_ex_b_br_pd), .o_ex_b_alu_op(o_ex_b_alu_op), .o_ex_b_imm(o_ex_b_imm),
        .o_ex_b_rdata1(o_ex_b_rdata1), .o_ex_b_rdata2(o_ex_b_rdata2),
        .o_ex_b_rf_we(o_ex_b_rf_we), .o_ex_b_rf_waddr(o_ex_b_rf_waddr),
        .o_ex_b_mem_we(o_ex_b_mem_we),
        .o_div_en(o_div_en), .o_mul_en(o_mul_en), .o_ertn_check(o_ertn_check),
        .o_cacop_en(o_cacop_en), .o_csr_rdata(o_csr_rdata)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the issue stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module issue_tb -o issue_sim \
    && ./obj_dir/issue_sim > sim.log \
    || { cat sim.log 2> /dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// File: sim.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/issue_lane.sv
rtl/issue_route.sv
rtl/issue_top.sv
verif/issue_tb.sv

// File: verif/issue_tb.sv
`include "issue_macros.svh"

module issue_tb import issue_pkg::*; ();

    localparam int N = 15;
    localparam int R = N;  // Reset expectation

    logic clk = 1'b0;
    logic rstn;
    logic stall_d, stall_e, flush;
    logic                     s_valid [2], s_we [2], s_mwe [2];
    logic [`ISSUE_XLEN-1:0]   s_pc [2], s_pre [2], s_imm [2], s_rd1 [2], s_rd2 [2], s_csr [2];
    logic [`ISSUE_REG_AW-1:0] s_wa [2];
    inst_class_e              s_cls [2];
    alu_op_e                  s_op [2];
    logic                     x_valid [2], x_brpd [2], x_we [2], x_mwe [2];  // [0] is lane A
    logic [`ISSUE_XLEN-1:0]   x_pc [2], x_npc [2], x_imm [2], x_rd1 [2], x_rd2 [2];
    logic [`ISSUE_REG_AW-1:0] x_wa [2];
    alu_op_e                  x_op [2];
    logic                     div_en, mul_en, ertn_chk, cacop_en;
    logic [`ISSUE_XLEN-1:0]   csr_rdata;

    ////////////////////////////////////////
    // Stimulus and expectation tables
    ////////////////////////////////////////

    logic                     t_valid [N][2], t_we [N][2], t_mwe [N][2];
    logic [`ISSUE_XLEN-1:0]   t_pc [N][2], t_pre [N][2], t_imm [N][2];
    logic [`ISSUE_XLEN-1:0]   t_rd1 [N][2], t_rd2 [N][2], t_csr [N][2];
    logic [`ISSUE_REG_AW-1:0] t_wa [N][2];
    inst_class_e              t_cls [N][2];
    alu_op_e                  t_op [N][2];
    logic                     t_sd [N], t_se [N], t_fl [N];
    logic                     e_valid [N+1][2], e_brpd [N+1][2], e_we [N+1][2], e_mwe [N+1][2];
    logic [`ISSUE_XLEN-1:0]   e_pc [N+1][2], e_npc [N+1][2], e_imm [N+1][2];
    logic [`ISSUE_XLEN-1:0]   e_rd1 [N+1][2], e_rd2 [N+1][2];
    logic [`ISSUE_REG_AW-1:0] e_wa [N+1][2];
    alu_op_e                  e_op [N+1][2];
    logic                     e_div [N+1], e_mul [N+1], e_ertn [N+1], e_cacop [N+1];
    logic [`ISSUE_XLEN-1:0]   e_csr [N+1];
    int                       exp_idx [N+1];  // Entry whose state is on the outputs
    int                       errors;
    int                       checks;

    always #2 clk = ~clk;

    issue_top dut0 (
        .clk(clk), .rstn(rstn), .i_stall_dcache(stall_d), .i_stall_ex(stall_e),
        .i_flush_br(flush),
        .i_s0_valid(s_valid[0]), .i_s0_pc(s_pc[0]), .i_s0_pc_pre(s_pre[0]),
        .i_s0_class(s_cls[0]), .i_s0_alu_op(s_op[0]), .i_s0_imm(s_imm[0]),
        .i_s0_rdata1(s_rd1[0]), .i_s0_rdata2(s_rd2[0]), .i_s0_csr_rdata(s_csr[0]),
        .i_s0_rf_we(s_we[0]), .i_s0_rf_waddr(s_wa[0]), .i_s0_mem_we(s_mwe[0]),
        .i_s1_valid(s_valid[1]), .i_s1_pc(s_pc[1]), .i_s1_pc_pre(s_pre[1]),
        .i_s1_class(s_cls[1]), .i_s1_alu_op(s_op[1]), .i_s1_imm(s_imm[1]),
        .i_s1_rdata1(s_rd1[1]), .i_s1_rdata2(s_rd2[1]), .i_s1_csr_rdata(s_csr[1]),
        .i_s1_rf_we(s_we[1]), .i_s1_rf_waddr(s_wa[1]), .i_s1_mem_we(s_mwe[1]),
        .o_ex_a_valid(x_valid[0]), .o_ex_a_pc(x_pc[0]), .o_ex_a_next_pc(x_npc[0]),
        .o_ex_a_br_pd(x_brpd[0]), .o_ex_a_alu_op(x_op[0]), .o_ex_a_imm(x_imm[0]),
        .o_ex_a_rdata1(x_rd1[0]), .o_ex_a_rdata2(x_rd2[0]), .o_ex_a_rf_we(x_we[0]),
        .o_ex_a_rf_waddr(x_wa[0]), .o_ex_a_mem_we(x_mwe[0]),
        .o_ex_b_valid(x_valid[1]), .o_ex_b_pc(x_pc[1]), .o_ex_b_next_pc(x_npc[1]),
        .o_ex_b_br_pd(x_brpd[1]), .o_ex_b_alu_op(x_op[1]), .o_ex_b_imm(x_imm[1]),
        .o_ex_b_rdata1(x_rd1[1]), .o_ex_b_rdata2(x_rd2[1]), .o_ex_b_rf_we(x_we[1]),
        .o_ex_b_rf_waddr(x_wa[1]), .o_ex_b_mem_we(x_mwe[1]),
        .o_div_en(div_en), .o_mul_en(mul_en), .o_ertn_check(ertn_chk),
        .o_cacop_en(cacop_en), .o_csr_rdata(csr_rdata)
    );

    task automatic fill_slot(input int i, input int s, input logic v, input inst_class_e c);
        logic [`ISSUE_XLEN-1:0] pc;
        pc = $urandom() & 32'hffff_fffc;
        t_valid[i][s] = v;
        t_cls[i][s]   = c;
        t_op[i][s]    = alu_op_e'(`ISSUE_OP_W'($urandom_range(9, 0)));
        t_pc[i][s]    = pc;
        t_pre[i][s]   = (((i + s) % 2) == 1) ? ($urandom() & 32'hffff_fffc)
                                             : pc + `ISSUE_XLEN'(`ISSUE_INST_BYTES);
        t_imm[i][s]   = $urandom();
        t_rd1[i][s]   = $urandom();
        t_rd2[i][s]   = $urandom();
        t_csr[i][s]   = $urandom();
        t_wa[i][s]    = `ISSUE_REG_AW'($urandom());
        t_we[i][s]    = !v || ((i % 2) == 1);     // Bubbles still ask for writes
        t_mwe[i][s]   = !v || ((i % 2) == 0);
    endtask

    task automatic fill_entry(input int i, input int v0, input inst_class_e c0, input int v1,
                              input inst_class_e c1, input int sd, input int se, input int fl);
        fill_slot(i, 0, v0 != 0, c0);
        fill_slot(i, 1, v1 != 0, c1);
        t_sd[i] = (sd != 0);
        t_se[i] = (se != 0);
        t_fl[i] = (fl != 0);
    endtask

    task automatic reset_expect(input int i);
        for (int l = 0; l < 2; l++) begin
            e_valid[i][l] = 1'b0;
            e_pc[i][l]    = '0;
            e_npc[i][l]   = `ISSUE_XLEN'(`ISSUE_INST_BYTES);
            e_brpd[i][l]  = 1'b0;
            e_op[i][l]    = OP_ADD;
            e_imm[i][l]   = '0;
            e_rd1[i][l]   = '0;
            e_rd2[i][l]   = '0;
            e_we[i][l]    = 1'b0;
            e_wa[i][l]    = '0;
            e_mwe[i][l]   = 1'b0;
        end
        e_div[i]   = 1'b0;
        e_mul[i]   = 1'b0;
        e_ertn[i]  = 1'b0;
        e_cacop[i] = 1'b0;
        e_csr[i]   = '0;
    endtask

    task automatic build_expect(input int i);
        int swap;
        int src;
        int bsrc;
        swap = (t_cls[i][0] != CLS_ALU) ? 1 : 0;
        bsrc = 1 - swap;
        exp_idx[i] = i;
        if (t_fl[i]) begin
            reset_expect(i);
        end else if (t_sd[i] || t_se[i]) begin
            exp_idx[i] = exp_idx[(i == 0) ? R : i - 1];  // Held state
        end else begin
            for (int l = 0; l < 2; l++) begin
                src = swap ^ l;
                e_valid[i][l] = t_valid[i][src];
                e_pc[i][l]    = t_pc[i][src];
                e_brpd[i][l]  = t_pre[i][src] != t_pc[i][src] + `ISSUE_XLEN'(`ISSUE_INST_BYTES);
                e_npc[i][l]   = t_valid[i][src] ? t_pre[i][src]
                                                : t_pc[i][src] + `ISSUE_XLEN'(`ISSUE_INST_BYTES);
                e_op[i][l]    = t_op[i][src];
                e_imm[i][l]   = t_imm[i][src];
                e_rd1[i][l]   = t_rd1[i][src];
                e_rd2[i][l]   = t_rd2[i][src];
                e_we[i][l]    = t_we[i][src] && t_valid[i][src];
                e_wa[i][l]    = t_wa[i][src];
                e_mwe[i][l]   = t_mwe[i][src] && t_valid[i][src];
            end
            e_div[i]   = t_valid[i][bsrc] && (t_cls[i][bsrc] == CLS_DIV);
            e_mul[i]   = t_valid[i][bsrc] && (t_cls[i][bsrc] == CLS_MUL);
            e_ertn[i]  = t_valid[i][bsrc] && (t_cls[i][bsrc] == CLS_ERTN);
            e_cacop[i] = t_valid[i][bsrc] && (t_cls[i][bsrc] == CLS_CACOP);
            e_csr[i]   = t_csr[i][bsrc];
        end
    endtask

    task automatic drive_entry(input int i);
        for (int s = 0; s < 2; s++) begin
            s_valid[s] = t_valid[i][s];
            s_pc[s]    = t_pc[i][s];
            s_pre[s]   = t_pre[i][s];
            s_cls[s]   = t_cls[i][s];
            s_op[s]    = t_op[i][s];
            s_imm[s]   = t_imm[i][s];
            s_rd1[s]   = t_rd1[i][s];
            s_rd2[s]   = t_rd2[i][s];
            s_csr[s]   = t_csr[i][s];
            s_we[s]    = t_we[i][s];
            s_wa[s]    = t_wa[i][s];
            s_mwe[s]   = t_mwe[i][s];
        end
        stall_d = t_sd[i];
        stall_e = t_se[i];
        flush   = t_fl[i];
    endtask

    task automatic drive_idle();
        for (int s = 0; s < 2; s++) begin
            s_valid[s] = 1'b0;
            s_pc[s]    = '0;
            s_pre[s]   = `ISSUE_XLEN'(`ISSUE_INST_BYTES);  // Same as the reset state
            s_cls[s]   = CLS_ALU;
            s_op[s]    = OP_ADD;
            s_imm[s]   = '0;
            s_rd1[s]   = '0;
            s_rd2[s]   = '0;
            s_csr[s]   = '0;
            s_we[s]    = 1'b0;
            s_wa[s]    = '0;
            s_mwe[s]   = 1'b0;
        end
        stall_d = 1'b1;  // Keep the reset state in the registers
        stall_e = 1'b0;
        flush   = 1'b0;
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic compare_field(input string name, input logic [`ISSUE_XLEN-1:0] got,
                                 input logic [`ISSUE_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s mismatch, got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_lane(input string lane, input int e, input int l, input alu_op_e op,
                              input logic v, brpd, we, mwe,
                              input logic [`ISSUE_XLEN-1:0] pc, npc, imm, rd1, rd2,
                              input logic [`ISSUE_REG_AW-1:0] wa);
        compare_field({lane, "_valid"}, `ISSUE_XLEN'(v), `ISSUE_XLEN'(e_valid[e][l]));
        compare_field({lane, "_pc"}, pc, e_pc[e][l]);
        compare_field({lane, "_next_pc"}, npc, e_npc[e][l]);
        compare_field({lane, "_br_pd"}, `ISSUE_XLEN'(brpd), `ISSUE_XLEN'(e_brpd[e][l]));
        compare_field({lane, "_alu_op"}, `ISSUE_XLEN'(op), `ISSUE_XLEN'(e_op[e][l]));
        compare_field({lane, "_imm"}, imm, e_imm[e][l]);
        compare_field({lane, "_rdata1"}, rd1, e_rd1[e][l]);
        compare_field({lane, "_rdata2"}, rd2, e_rd2[e][l]);
        compare_field({lane, "_rf_we"}, `ISSUE_XLEN'(we), `ISSUE_XLEN'(e_we[e][l]));
        compare_field({lane, "_rf_waddr"}, `ISSUE_XLEN'(wa), `ISSUE_XLEN'(e_wa[e][l]));
        compare_field({lane, "_mem_we"}, `ISSUE_XLEN'(mwe), `ISSUE_XLEN'(e_mwe[e][l]));
    endtask

    task automatic check_special(input int e, input logic div, mul, ertn, cacop,
                                 input logic [`ISSUE_XLEN-1:0] csr);
        compare_field("div_en", `ISSUE_XLEN'(div), `ISSUE_XLEN'(e_div[e]));
        compare_field("mul_en", `ISSUE_XLEN'(mul), `ISSUE_XLEN'(e_mul[e]));
        compare_field("ertn_check", `ISSUE_XLEN'(ertn), `ISSUE_XLEN'(e_ertn[e]));
        compare_field("cacop_en", `ISSUE_XLEN'(cacop), `ISSUE_XLEN'(e_cacop[e]));
        compare_field("csr_rdata", csr, e_csr[e]);
    endtask

    task automatic check_outputs(input int e);
        check_lane("ex_a", e, 0, x_op[0], x_valid[0], x_brpd[0], x_we[0], x_mwe[0],
                   x_pc[0], x_npc[0], x_imm[0], x_rd1[0], x_rd2[0], x_wa[0]);
        check_lane("ex_b", e, 1, x_op[1], x_valid[1], x_brpd[1], x_we[1], x_mwe[1],
                   x_pc[1], x_npc[1], x_imm[1], x_rd1[1], x_rd2[1], x_wa[1]);
        check_special(e, div_en, mul_en, ertn_chk, cacop_en, csr_rdata);
    endtask

    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstn = 1'b1;
    end

    initial begin
        int waited;
        errors = 0;
        checks = 0;
        void'($urandom(32'h73e71a2b));
        drive_idle();
        fill_entry(0,  1, CLS_ALU,   1, CLS_ALU,   0, 0, 0);  // Straight through
        fill_entry(1,  1, CLS_DIV,   1, CLS_ALU,   0, 0, 0);  // Crossover
        fill_entry(2,  1, CLS_MUL,   1, CLS_ALU,   0, 0, 0);
        fill_entry(3,  1, CLS_ERTN,  0, CLS_ALU,   0, 0, 0);
        fill_entry(4,  1, CLS_CACOP, 1, CLS_ALU,   0, 0, 0);
        fill_entry(5,  1, CLS_ALU,   1, CLS_MUL,   0, 0, 0);  // Special in slot 1
        fill_entry(6,  1, CLS_ALU,   0, CLS_DIV,   0, 0, 0);  // Invalid, no enable
        fill_entry(7,  0, CLS_ALU,   1, CLS_CACOP, 0, 0, 0);
        fill_entry(8,  1, CLS_DIV,   1, CLS_ALU,   1, 0, 0);  // Dcache stall
        fill_entry(9,  0, CLS_ALU,   1, CLS_ERTN,  0, 1, 0);  // EX stall
        fill_entry(10, 1, CLS_ERTN,  1, CLS_ALU,   0, 0, 0);
        fill_entry(11, 1, CLS_MUL,   1, CLS_ALU,   1, 1, 1);  // Flush beats stall
        fill_entry(12, 1, CLS_ALU,   1, CLS_ALU,   0, 0, 0);
        fill_entry(13, 1, CLS_CACOP, 0, CLS_DIV,   0, 0, 1);
        fill_entry(14, 0, CLS_DIV,   1, CLS_DIV,   0, 0, 0);  // Invalid slot 0 in lane B
        reset_expect(R);
        exp_idx[R] = R;
        for (int i = 0; i < N; i++) begin
            build_expect(i);
        end
        waited = 0;
        while (rstn !== 1'b1 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (rstn !== 1'b1) begin
            $display("Timeout: reset was never released");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            @(posedge clk);
            #1;
            check_outputs(R);
            for (int i = 0; i < N; i++) begin
                drive_entry(i);
                @(posedge clk);
                #1;
                check_outputs(exp_idx[i]);
            end
            $display("Errors: %0d in %0d checks", errors, checks);
            if (errors == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule
